// File: Prbs9Tester.f
+incdir+.
Prbs9Pkg.sv
Prbs9GenLane.sv
Prbs9ChkLane.sv
Prbs9ChkX8.sv
Prbs9Tester.sv
Prbs9TbClk.sv
Prbs9Tester_assert.sv
Prbs9TesterTb.sv

// File: Makefile
LOG = sim.log

.PHONY: all run lint clean

all: run

run:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module Prbs9TesterTb -f Prbs9Tester.f -Mdir obj_dir -o Prbs9TesterTb
	./obj_dir/Prbs9TesterTb | tee $(LOG)
	grep -q "^test passed$$" $(LOG)

lint:
	verilator --lint-only --timing --assert --timescale 1ns/1ps \
		--top-module Prbs9TesterTb -f Prbs9Tester.f

clean:
	rm -rf obj_dir $(LOG)

// File: Prbs9TesterTb.sv
`timescale 1ns/1ps
`include "prbs9_consts.svh"

module Prbs9TesterTb;

	localparam int WinW   = 5;            // 32-cycle window
	localparam int WinLen = 1 << WinW;
	// Reset plus about 100 generator clocks and six windows, four times over
	localparam int TimeoutCycles = 4 * (8 + 100 + 6 * WinLen);
	localparam Prbs9Pkg::lfsrT LaneTaps [`PRBS_LANES] = `PRBS_TAPS_TBL;

	logic               SysClk;
	logic               Reset_N;
	logic               GenEn;
	logic               ChkEn;
	Prbs9Pkg::laneWordT DataOut;
	Prbs9Pkg::laneWordT DataIn;           // Loopback register
	Prbs9Pkg::laneWordT Error;
	Prbs9Pkg::laneWordT Right;

	Prbs9Pkg::lfsrT ModelState [`PRBS_LANES];    // Reference PRBS per lane
	int             ChkCnt   = 0;         // Enabled checker edges so far
	int             CycleCnt = 0;
	int             Seed     = 95;

	Prbs9TbClk iTbClk
	(
		.SysClk  (SysClk),
		.Reset_N (Reset_N)
	);

	Prbs9Tester #(.WinW(WinW)) i_dut
	(
		.SysClk  (SysClk),
		.Reset_N (Reset_N),
		.GenEn   (GenEn),
		.DataOut (DataOut),
		.ChkEn   (ChkEn),
		.DataIn  (DataIn),
		.Error   (Error),
		.Right   (Right)
	);

	////////////////////////////////////////////////////////////
	// Reporting
	task automatic failRun(input string reason);
		$display("%s", reason);
		$display("test failed");
		$fatal(1);
	endtask

	task automatic checkValue(input string name, input Prbs9Pkg::laneWordT expected,
		input Prbs9Pkg::laneWordT actual);
		if (actual !== expected)
		begin
			failRun($sformatf("FAILED %s expected %h got %h", name, expected, actual));
		end
	endtask

	always @(posedge SysClk)
	begin
		CycleCnt <= CycleCnt + 1;
		if (CycleCnt >= TimeoutCycles)
		begin
			failRun("Timeout, the tests did not finish within the cycle limit");
		end
	end

	////////////////////////////////////////////////////////////
	// Reference model and stimulus
	task automatic advanceModel();
		for (int i = 0; i < `PRBS_LANES; i++)
		begin
			if (ModelState[i] == '0)
			begin
				ModelState[i] = LaneTaps[i];    // Seed from the taps
			end
			else
			begin
				ModelState[i] = {ModelState[i][`PRBS_LEN-2:0], ^(ModelState[i] & LaneTaps[i])};
			end
		end
	endtask

	function automatic Prbs9Pkg::laneWordT modelOut();
		Prbs9Pkg::laneWordT word;
		for (int i = 0; i < `PRBS_LANES; i++)
		begin
			word[i] = ModelState[i][`PRBS_LEN-1];
		end
		return word;
	endfunction

	task automatic pickRandom(input int limit, output int value);
		value = $unsigned($random(Seed)) % limit;
	endtask

	// Model steps on the enables applied last cycle
	task automatic tick(input logic genEn, input logic chkEn, input Prbs9Pkg::laneWordT injMask);
		@(negedge SysClk);
		if (GenEn)
		begin
			advanceModel();
		end
		if (ChkEn)
		begin
			ChkCnt++;
		end
		GenEn  = genEn;
		ChkEn  = chkEn;
		DataIn = DataOut ^ injMask;      // Loopback with optional flip
	endtask

	task automatic runToUpdate();
		do
		begin
			tick(1'b1, 1'b1, '0);
		end
		while (ChkCnt % WinLen != 1);    // Right loads two edges after window end
	endtask

	////////////////////////////////////////////////////////////
	// Directed tests
	task automatic resetTest();
		@(posedge Reset_N);
		checkValue("Error", '1, Error);
		checkValue("Right", '0, Right);
	endtask

	task automatic genSeqTest();
		tick(1'b1, 1'b0, '0);
		repeat (60)
		begin
			tick(1'b1, 1'b0, '0);
			checkValue("DataOut", modelOut(), DataOut);
		end
	endtask

	task automatic genHoldTest();
		int                 holdLen;
		Prbs9Pkg::laneWordT held;
		pickRandom(8, holdLen);
		tick(1'b0, 1'b0, '0);
		checkValue("DataOut", modelOut(), DataOut);
		held = modelOut();
		repeat (holdLen + 1)
		begin
			tick(1'b0, 1'b0, '0);
			checkValue("DataOut", held, DataOut);
		end
		repeat (20)
		begin
			tick(1'b1, 1'b0, '0);
			checkValue("DataOut", modelOut(), DataOut);
		end
	endtask

	task automatic cleanLoopTest();
		while (ChkCnt < 12 + WinLen)
		begin
			tick(1'b1, 1'b1, '0);
			if (ChkCnt >= 12)
			begin
				checkValue("Error", '0, Error);    // Locked by now
			end
			checkValue("Right", '0, Right);
		end
	endtask

	task automatic errorLatencyTest();
		int                 lane;
		int                 delay;
		bit                 seen;
		Prbs9Pkg::laneWordT mask;
		pickRandom(`PRBS_LANES, lane);
		pickRandom(8, delay);
		mask = Prbs9Pkg::laneWordT'(1 << lane);
		seen = 1'b0;
		repeat (2 + delay)
		begin
			tick(1'b1, 1'b1, '0);
			checkValue("Error", '0, Error);
		end
		tick(1'b1, 1'b1, mask);          // One flipped bit
		for (int n = 0; n < 12 && !seen; n++)
		begin
			tick(1'b1, 1'b1, '0);
			checkValue("Error", '0, Error & ~mask);
			seen = Error[lane];
		end
		if (!seen)
		begin
			failRun("Error did not rise within twelve enabled cycles of the injected bit");
		end
		repeat (11)
		begin
			tick(1'b1, 1'b1, '0);
			checkValue("Error", '0, Error & ~mask);
		end
		repeat (17)
		begin
			tick(1'b1, 1'b1, '0);
			checkValue("Error", '0, Error);    // Relocked
		end
	endtask

	task automatic windowTest();
		int                 lane;
		int                 delay;
		Prbs9Pkg::laneWordT mask;
		runToUpdate();                   // Skip a window touched by earlier tests
		runToUpdate();
		checkValue("Right", '1, Right);
		pickRandom(`PRBS_LANES, lane);
		pickRandom(8, delay);
		mask = Prbs9Pkg::laneWordT'(1 << lane);
		repeat (4 + delay)
		begin
			tick(1'b1, 1'b1, '0);
		end
		tick(1'b1, 1'b1, mask);
		runToUpdate();
		checkValue("Right", ~mask, Right);
	endtask

	initial
	begin
		GenEn  = 1'b0;
		ChkEn  = 1'b0;
		DataIn = '0;
		for (int i = 0; i < `PRBS_LANES; i++)
		begin
			ModelState[i] = '0;          // Lanes come out of reset at zero
		end
		resetTest();
		genSeqTest();
		genHoldTest();
		cleanLoopTest();
		errorLatencyTest();
		windowTest();
		$display("test passed");
		$finish;
	end

endmodule

// File: Prbs9Tester_assert.sv
`timescale 1ns/1ps
`include "prbs9_consts.svh"

module Prbs9TesterAssert
#(
	parameter int WinW = `PRBS_WIN_W     // Must follow the bound instance
)
(
	input logic               SysClk,
	input logic               Reset_N,
	input logic               GenEn,
	input logic               ChkEn,
	input Prbs9Pkg::laneWordT DataOut,
	input Prbs9Pkg::laneWordT Error,
	input Prbs9Pkg::laneWordT Right
);

	logic [WinW-1:0] EnCnt;              // Mirrors the window counter

	always_ff @(posedge SysClk or negedge Reset_N)
	begin
		if (!Reset_N)
		begin
			EnCnt <= '0;
		end
		else if (ChkEn)
		begin
			EnCnt <= EnCnt + WinW'(1);
		end
	end

	////////////////////////////////////////////////////////////
	// Summary only moves two clocks after the last window cycle
	RightOnUpdate: assert property (@(posedge SysClk) disable iff (!Reset_N)
		$changed(Right) |-> $past(ChkEn & (&EnCnt), 2))
		else $error("Right changed outside a window update");

	GenHold: assert property (@(posedge SysClk) disable iff (!Reset_N)
		!GenEn |=> $stable(DataOut))
		else $error("DataOut moved while GenEn was low");

	ErrAfterReset: assert property (@(posedge SysClk)
		$rose(Reset_N) |-> (Error == '1))
		else $error("Error not all ones right after reset");

endmodule

bind Prbs9Tester Prbs9TesterAssert #(.WinW(WinW)) iAssert
(
	.SysClk  (SysClk),
	.Reset_N (Reset_N),
	.GenEn   (GenEn),
	.ChkEn   (ChkEn),
	.DataOut (DataOut),
	.Error   (Error),
	.Right   (Right)
);

// File: Prbs9TbClk.sv
`timescale 1ns/1ps

module Prbs9TbClk
(
	output logic SysClk,                 // 40 ns testbench clock
	output logic Reset_N                 // Low for the first eight cycles
);

	localparam int HalfPeriod = 20;      // ns

	initial
	begin
		SysClk = 1'b0;
		forever #HalfPeriod SysClk = ~SysClk;
	end

	initial
	begin
		Reset_N = 1'b0;
		repeat (8) @(posedge SysClk);
		@(negedge SysClk);               // Release away from the active edge
		Reset_N = 1'b1;
	end

endmodule

// File: Prbs9Tester.sv
`timescale 1ns/1ps
`include "prbs9_consts.svh"

module Prbs9Tester
#(
	parameter int WinW = `PRBS_WIN_W     // Checker window width
)
(
	input  logic               SysClk,   // System clock
	input  logic               Reset_N,  // Async reset, active low
	input  logic               GenEn,    // Generator clock enable
	output Prbs9Pkg::laneWordT DataOut,  // Transmit lanes
	input  logic               ChkEn,    // Checker clock enable
	input  Prbs9Pkg::laneWordT DataIn,   // Receive lanes
	output Prbs9Pkg::laneWordT Error,    // Per-lane bit error
	output Prbs9Pkg::laneWordT Right     // Window summary
);

	localparam Prbs9Pkg::lfsrT TapTbl [`PRBS_LANES] = `PRBS_TAPS_TBL;

	////////////////////////////////////////////////////////////
	// Generator half
	genvar Lane;
	generate
		for (Lane = 0; Lane < `PRBS_LANES; Lane++)
		begin : gGenLane
			Prbs9GenLane
			#(
				.Taps    (TapTbl[Lane])
			)
			iGenLane
			(
				.SysClk  (SysClk),
				.Reset_N (Reset_N),
				.ClkEn   (GenEn),
				.DataOut (DataOut[Lane])
			);
		end
	endgenerate

	////////////////////////////////////////////////////////////
	// Checker half, independent of generator
	Prbs9ChkX8
	#(
		.WinW    (WinW)
	)
	iChkX8
	(
		.SysClk  (SysClk),
		.Reset_N (Reset_N),
		.ChkEn   (ChkEn),
		.DataIn  (DataIn),
		.Error   (Error),
		.Right   (Right)
	);

endmodule

// File: Prbs9ChkX8.sv
`timescale 1ns/1ps
`include "prbs9_consts.svh"

module Prbs9ChkX8
#(
	parameter int WinW = `PRBS_WIN_W     // Window is 2^WinW enabled cycles
)
(
	input  logic               SysClk,   // System clock
	input  logic               Reset_N,  // Async reset, active low
	input  logic               ChkEn,    // Checker clock enable
	input  Prbs9Pkg::laneWordT DataIn,   // Received lanes
	output Prbs9Pkg::laneWordT Error,    // Per-lane error, every clock
	output Prbs9Pkg::laneWordT Right     // Error-free over last window
);

	// Per-lane polynomial, indexed by lane
	localparam Prbs9Pkg::lfsrT TapTbl [`PRBS_LANES] = `PRBS_TAPS_TBL;

	////////////////////////////////////////////////////////////
	// Checker lanes
	genvar Lane;
	generate
		for (Lane = 0; Lane < `PRBS_LANES; Lane++)
		begin : gChkLane
			Prbs9ChkLane
			#(
				.Taps    (TapTbl[Lane])           // Lane's own polynomial
			)
			iChkLane
			(
				.SysClk  (SysClk),
				.Reset_N (Reset_N),
				.ClkEn   (ChkEn),
				.DataIn  (DataIn[Lane]),
				.Error   (Error[Lane])
			);
		end
	endgenerate

	////////////////////////////////////////////////////////////
	// Window counter and end-of-window pulse
	logic [WinW-1:0] WinCnt;             // Counts ChkEn cycles
	logic            WinPulse;           // One clock after last counted cycle

	always_ff @(posedge SysClk or negedge Reset_N)
	begin
		if (!Reset_N)
		begin
			WinCnt   <= '0;
			WinPulse <= 1'b0;
		end
		else
		begin
			if (ChkEn)
			begin
				WinCnt <= WinCnt + WinW'(1);    // Wraps at window end
			end
			WinPulse <= ChkEn & (&WinCnt);    // Last cycle of window
		end
	end

	////////////////////////////////////////////////////////////
	// Sticky error-free flags and summary
	Prbs9Pkg::laneWordT ErrFree;         // Cleared by any Error in window

	always_ff @(posedge SysClk or negedge Reset_N)
	begin
		if (!Reset_N)
		begin
			ErrFree <= '0;               // First window reports zero
			Right   <= '0;
		end
		else if (WinPulse)
		begin
			Right   <= ErrFree;          // Publish finished window
			ErrFree <= '1;               // Rearm for next window
		end
		else
		begin
			ErrFree <= ErrFree & ~Error;    // Any error sticks low
		end
	end

endmodule

// File: Prbs9ChkLane.sv
`timescale 1ns/1ps
`include "prbs9_consts.svh"

module Prbs9ChkLane
#(
	parameter Prbs9Pkg::lfsrT Taps = `PRBS_TAPS_0    // Must match the far-end lane
)
(
	input  logic SysClk,                 // System clock
	input  logic Reset_N,                // Async reset, active low
	input  logic ClkEn,                  // Sample DataIn this cycle
	input  logic DataIn,                 // Received serial bit
	output logic Error                   // Registered mismatch flag
);

	////////////////////////////////////////////////////////////
	// Receive shift register, last nine received bits
	Prbs9Pkg::lfsrT RxShift;             // Newest bit in LSB

	always_ff @(posedge SysClk or negedge Reset_N)
	begin
		if (!Reset_N)
		begin
			RxShift <= '0;
		end
		else if (ClkEn)
		begin
			RxShift <= {RxShift[`PRBS_LEN-2:0], DataIn};    // Shift in
		end
	end

	////////////////////////////////////////////////////////////
	// Reference LFSR, relocks on the received stream
	Prbs9Pkg::lfsrT RefLfsr;             // Expected state
	logic           RefFeed;             // Predicted next bit
	logic           Mismatch;            // Rx and reference disagree

	assign RefFeed  = ^(RefLfsr & Taps);
	assign Mismatch = (RxShift != RefLfsr);

	always_ff @(posedge SysClk or negedge Reset_N)
	begin
		if (!Reset_N)
		begin
			RefLfsr <= '0;
		end
		else if (ClkEn)
		begin
			if (Mismatch)
			begin
				RefLfsr <= {RxShift[`PRBS_LEN-2:0], DataIn};    // Resync to line data
			end
			else if (|RefLfsr)
			begin
				RefLfsr <= {RefLfsr[`PRBS_LEN-2:0], RefFeed};    // Free-run step
			end
			else
			begin
				RefLfsr <= Taps;         // Same seed rule as generator
			end
		end
	end

	// Compared on every clock, enable or not
	always_ff @(posedge SysClk or negedge Reset_N)
	begin
		if (!Reset_N)
		begin
			Error <= 1'b1;               // Unlocked out of reset
		end
		else
		begin
			Error <= Mismatch;
		end
	end

endmodule

// File: Prbs9GenLane.sv
`timescale 1ns/1ps
`include "prbs9_consts.svh"

module Prbs9GenLane
#(
	parameter Prbs9Pkg::lfsrT Taps = `PRBS_TAPS_0    // Polynomial mask and seed
)
(
	input  logic SysClk,                 // System clock
	input  logic Reset_N,                // Async reset, active low
	input  logic ClkEn,                  // Advance one bit
	output logic DataOut                 // Serial PRBS bit
);

	////////////////////////////////////////////////////////////
	// Fibonacci LFSR, shifts toward the MSB
	Prbs9Pkg::lfsrT PrbsState;           // LFSR state
	logic           FeedBit;             // New LSB

	assign FeedBit = ^(PrbsState & Taps);    // XOR of tapped bits

	always_ff @(posedge SysClk or negedge Reset_N)
	begin
		if (!Reset_N)
		begin
			PrbsState <= '0;             // Zero until first enable
		end
		else if (ClkEn)
		begin
			if (|PrbsState)
			begin
				PrbsState <= {PrbsState[`PRBS_LEN-2:0], FeedBit};    // Normal step
			end
			else
			begin
				PrbsState <= Taps;       // Self-seed, zero is a lockup state
			end
		end
	end

	assign DataOut = PrbsState[`PRBS_LEN-1];    // MSB goes on the line

endmodule

// File: Prbs9Pkg.sv
`include "prbs9_consts.svh"

////////////////////////////////////////////////////////////
// Types shared by generator and checker halves
package Prbs9Pkg;

	// One bit per lane
	typedef logic [`PRBS_LANES-1:0] laneWordT;

	// LFSR and receive register state
	typedef logic [`PRBS_LEN-1:0] lfsrT;

endpackage

// File: prbs9_consts.svh
`ifndef PRBS9_CONSTS_SVH
`define PRBS9_CONSTS_SVH

////////////////////////////////////////////////////////////
// Lane and LFSR geometry
`define PRBS_LANES 8                   // Parallel lanes per side
`define PRBS_LEN 9                     // PRBS9 state length

////////////////////////////////////////////////////////////
// Tap masks, one per lane, also used as the seed value
`define PRBS_TAPS_0 9'b1_0001_0000     // 1041, x9+x5+1
`define PRBS_TAPS_1 9'b1_0000_1000     // 1021
`define PRBS_TAPS_2 9'b1_0010_1100     // 1131
`define PRBS_TAPS_3 9'b1_1001_1000     // 1461
`define PRBS_TAPS_4 9'b1_1000_1001     // 1423
`define PRBS_TAPS_5 9'b1_0001_0110     // 1055
`define PRBS_TAPS_6 9'b1_0011_1011     // 1167
`define PRBS_TAPS_7 9'b1_1011_0000     // 1541
`define PRBS_TAPS_TBL '{`PRBS_TAPS_0, `PRBS_TAPS_1, `PRBS_TAPS_2, `PRBS_TAPS_3, \
	`PRBS_TAPS_4, `PRBS_TAPS_5, `PRBS_TAPS_6, `PRBS_TAPS_7}

// Window counter width, 2^20 enabled cycles per window
`define PRBS_WIN_W 20

`endif
